/* hw/video_macros.svh */
// Video controller constants
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// raster totals, in pixel periods and lines
`define VID_H_TOTAL 448 // 88 blank + 360 active max
`define VID_V_TOTAL 320 // 32 blank + 288 active max

// CPU register map
`define VID_REG_VCONF   8'h00 // mode, resolution, nogfx
`define VID_REG_VPAGE   8'h01 // video page
`define VID_REG_XOFFS_L 8'h02 // scroll offset bits 7:0
`define VID_REG_XOFFS_H 8'h03 // scroll offset bit 8 in data bit 0

// classic page port, page write that is taken mid-line
`define VID_REG_7FFD    8'hfd

// phase divider reaches c3 at this count
`define VID_PH_C3       2'd3

// one line before wrap
`define VID_H_LAST      (`VID_H_TOTAL - 1)
`define VID_V_LAST      (`VID_V_TOTAL - 1)

`endif

/* hw/video_cfg_pkg.sv */
// Video configuration types
package video_cfg_pkg;

	// video modes, as written by the CPU
	typedef enum logic [2:0]
	{
		M_ZX = 3'h0, // ZX screen
		M_HC = 3'h1, // 16 colours
		M_XC = 3'h2, // 256 colours
		M_TX = 3'h3, // text
		M_T2 = 3'h4, // reserved, falls back to ZX
		M_T0 = 3'h5, // ZX hi-res test
		M_T1 = 3'h6, // reserved
		M_T3 = 3'h7  // reserved
	} vid_mode_e;

	// renderer modes
	typedef enum logic [1:0]
	{
		R_ZX = 2'h0,
		R_HC = 2'h1,
		R_XC = 2'h2,
		R_TX = 2'h3
	} vid_render_e;

	// raster resolutions
	typedef enum logic [1:0]
	{
		RES_256X192 = 2'h0,
		RES_320X200 = 2'h1,
		RES_320X240 = 2'h2,
		RES_360X288 = 2'h3
	} vid_rres_e;

	// configuration byte layout, msb first
	typedef struct packed
	{
		vid_rres_e  rres;  // bits 7:6
		logic       nogfx; // bit 5, graphics off
		logic [1:0] rsvd;  // bits 4:3
		vid_mode_e  mode;  // low bits
	} vid_conf_t;

	// visible window in raster coordinates
	typedef struct packed
	{
		logic [8:0] hpix_beg;
		logic [8:0] hpix_end;
		logic [8:0] vpix_beg;
		logic [8:0] vpix_end;
		logic [5:0] x_tiles; // tiles per line incl. partial one
	} vid_window_t;

endpackage

/* hw/video_fetch_pkg.sv */
// Video fetch types
package video_fetch_pkg;

	// raster position as seen by the decoder
	typedef struct packed
	{
		logic [7:0] cnt_col;    // column inside window
		logic [8:0] cnt_row;    // row inside window
		logic       cptr;       // column parity
		logic [3:0] fetch_cnt;  // fetch phase
		logic       pix_start;  // window begin, on c3
		logic       line_start; // hcount zero, on c3
	} vid_pos_t;

	// DRAM fetch request
	typedef struct packed
	{
		logic        stb;  // one cycle, on c3
		logic [20:0] addr; // DRAM word address
		logic [3:0]  sel;  // byte lanes to latch
		logic [1:0]  bsl;  // byte select
		logic [4:0]  bw;   // bandwidth class
		logic [7:0]  col;
		logic [8:0]  row;
	} vid_fetch_t;

endpackage

/* hw/video_regs.sv */
// Video register block
`timescale 1ns/100ps
`include "video_macros.svh"

module video_regs
(
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      wr_stb,  // single cycle CPU write
	input  logic [7:0]                wr_addr,
	input  logic [7:0]                wr_data,
	output video_cfg_pkg::vid_conf_t  vconf,
	output logic [7:0]                vpage,
	output logic [8:0]                x_offs,
	output logic                      page_wr  // pulse after 7ffd write
);

	import video_cfg_pkg::*;

	logic wr_7ffd; // page port hit

	assign wr_7ffd = wr_stb && (wr_addr == `VID_REG_7FFD);

	// config, page and scroll registers
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vconf  <= '0; // M_ZX, 256x192
			vpage  <= '0;
			x_offs <= '0;
		end
		else if (wr_stb)
		begin
			case (wr_addr)
				`VID_REG_VCONF:   vconf       <= vid_conf_t'(wr_data);
				`VID_REG_VPAGE:   vpage       <= wr_data; // taken at line start
				`VID_REG_XOFFS_L: x_offs[7:0] <= wr_data;
				`VID_REG_XOFFS_H: x_offs[8]   <= wr_data[0];
				`VID_REG_7FFD:    vpage       <= wr_data; // also taken mid-line
				default:          ;
			endcase
		end
	end

	// strobe lines up with the new vpage value
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			page_wr <= 1'b0;
		else
			page_wr <= wr_7ffd;
	end

endmodule

/* hw/video_raster.sv */
// Raster timing
`timescale 1ns/100ps
`include "video_macros.svh"

module video_raster
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  video_cfg_pkg::vid_window_t window, // from the decoder
	output video_fetch_pkg::vid_pos_t  pos,
	output logic                       f1,     // every 2nd clk
	output logic                       c3      // every 4th clk
);

	import video_cfg_pkg::*;
	import video_fetch_pkg::*;

	logic [1:0] ph;   // clock phase divider
	logic [8:0] hcnt; // pixel period in line
	logic [8:0] vcnt; // line in frame
	logic       h_last;
	logic       vis_h;
	logic       vis_v;
	logic       vis;

	assign f1 = ph[0];
	assign c3 = (ph == `VID_PH_C3);

	assign h_last = (hcnt == 9'(`VID_H_LAST));
	assign vis_h  = (hcnt >= window.hpix_beg) && (hcnt < window.hpix_end);
	assign vis_v  = (vcnt >= window.vpix_beg) && (vcnt < window.vpix_end);
	assign vis    = vis_h && vis_v;

	// strobes ride on c3
	assign pos.line_start = c3 && (hcnt == 9'd0);
	assign pos.pix_start  = c3 && vis_v && (hcnt == window.hpix_beg);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ph <= '0;
		else
			ph <= ph + 2'd1;
	end

	// horizontal and vertical counters
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (c3)
		begin
			hcnt <= h_last ? 9'd0 : hcnt + 9'd1;
			if (h_last)
				vcnt <= (vcnt == 9'(`VID_V_LAST)) ? 9'd0 : vcnt + 9'd1;
		end
	end

	// column side, held at zero outside the window so it restarts at pix_start
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pos.cnt_col   <= '0;
			pos.cptr      <= 1'b0;
			pos.fetch_cnt <= '0;
		end
		else if (c3)
		begin
			if (vis)
			begin
				pos.cnt_col   <= pos.cnt_col + 8'd1;
				pos.cptr      <= ~pos.cptr;
				pos.fetch_cnt <= pos.fetch_cnt + 4'd1;
			end
			else
			begin
				pos.cnt_col   <= '0;
				pos.cptr      <= 1'b0;
				pos.fetch_cnt <= '0; // no phase match at zero, so no fetch
			end
		end
	end

	// row counts visible lines only
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pos.cnt_row <= '0;
		else if (c3 && h_last)
			pos.cnt_row <= vis_v ? pos.cnt_row + 9'd1 : 9'd0;
	end

endmodule

/* hw/video_mode.sv */
// Video mode decoder
`timescale 1ns/100ps

module video_mode
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  video_cfg_pkg::vid_conf_t    vconf,
	input  logic [7:0]                  vpage,
	input  logic [8:0]                  x_offs,
	input  logic                        page_wr,
	input  video_fetch_pkg::vid_pos_t   pos,
	input  logic                        f1,
	input  logic                        c3,
	input  logic [15:0]                 txt_char, // two char codes from DRAM
	output video_cfg_pkg::vid_window_t  window,
	output video_cfg_pkg::vid_render_e  render_mode,
	output logic [9:0]                  x_offs_mode,
	output logic [4:0]                  go_offs,
	output logic                        pix_stb,
	output logic                        tv_hires,
	output logic                        vga_hires,
	output logic                        nogfx,
	output video_fetch_pkg::vid_fetch_t fetch,
	output logic [7:0]                  vpage_d
);

	import video_cfg_pkg::*;
	import video_fetch_pkg::*;

	vid_conf_t   vconf_d;  // per-line copy
	logic [8:0]  x_offs_d;
	vid_mode_e   vmod;
	logic        line_cyc;
	logic        ftch;     // fetch phase match
	logic [3:0]  sel_zx;
	logic [3:0]  txt_sel;
	logic [1:0]  txt_bsl;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [20:0] addr_zx;
	logic [20:0] addr_16c;
	logic [20:0] addr_256c;
	logic [13:0] addr_tx;
	logic [20:0] addr_text;

	assign vmod     = vconf_d.mode;
	assign nogfx    = vconf_d.nogfx;
	assign line_cyc = pos.line_start && c3;

	// config and scroll taken once per line, hires seen by vga a line late
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vconf_d   <= '0;
			x_offs_d  <= '0;
			vga_hires <= 1'b0;
		end
		else if (line_cyc)
		begin
			vconf_d   <= vconf;
			x_offs_d  <= x_offs;
			vga_hires <= tv_hires;
		end
	end

	// page also follows a 7ffd write mid-line
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vpage_d <= '0;
		else if (line_cyc || page_wr)
			vpage_d <= vpage;
	end

	assign tv_hires = (vmod == M_TX) || (vmod == M_T0); // double pixel rate
	assign pix_stb  = tv_hires ? f1 : c3;

	// 16c moves by half, 256c by double, bit 0 kept as fine step
	assign x_offs_mode = {(vmod == M_XC) ? {x_offs_d[8:1], 1'b0} : {1'b0, x_offs_d[8:1]},
		x_offs_d[0]};

	// ZX: pixels at even columns, attributes at odd ones
	assign sel_zx      = {~pos.cptr, ~pos.cptr, pos.cptr, pos.cptr};
	assign addr_zx_gfx = {pos.cnt_row[7:6], pos.cnt_row[2:0], pos.cnt_row[5:3], pos.cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, pos.cnt_row[7:3], pos.cnt_col[4:1]};
	assign addr_zx     = {vpage_d, 1'b0, pos.cnt_col[0] ? addr_zx_atr : addr_zx_gfx};
	assign addr_16c    = {vpage_d[7:3], pos.cnt_row, pos.cnt_col[6:0]}; // linear
	assign addr_256c   = {vpage_d[7:4], pos.cnt_row, pos.cnt_col};      // linear
	assign addr_text   = {vpage_d[7:1], addr_tx};

	// text phase table, col counter already advanced at fetch time
	always_comb
	begin
		case (pos.cnt_col[1:0])
			2'd0:
			begin
				txt_sel = 4'b0010; // font of char1
				txt_bsl = {2{pos.cnt_row[0]}};
				addr_tx = {~vpage_d[0], 3'b000, txt_char[15:8], pos.cnt_row[2:1]};
			end
			2'd1:
			begin
				txt_sel = 4'b0011; // char codes
				txt_bsl = 2'b10;
				addr_tx = {vpage_d[0], pos.cnt_row[8:3], 1'b0, pos.cnt_col[7:2]};
			end
			2'd2:
			begin
				txt_sel = 4'b1100; // attributes
				txt_bsl = 2'b10;
				addr_tx = {vpage_d[0], pos.cnt_row[8:3], 1'b1, pos.cnt_col[7:2]};
			end
			default:
			begin
				txt_sel = 4'b0001; // font of char0
				txt_bsl = {2{pos.cnt_row[0]}};
				addr_tx = {~vpage_d[0], 3'b000, txt_char[7:0], pos.cnt_row[2:1]};
			end
		endcase
	end

	// mode table, bw[4:3] cycle group 11=8 01=4 00=2, bw[2:0] cycles used
	always_comb
	begin
		render_mode = R_ZX; // reserved modes fall back to ZX
		go_offs     = 5'd18;
		fetch.bw    = 5'b11001; // 1 of 8
		fetch.sel   = sel_zx;
		fetch.bsl   = 2'b10;
		fetch.addr  = addr_zx;
		case (vmod)
			M_HC:
			begin
				render_mode = R_HC;
				go_offs     = 5'd6;
				fetch.bw    = 5'b01001; // 1 of 4
				fetch.sel   = {~pos.cptr, ~pos.cptr, 2'b11};
				fetch.addr  = addr_16c;
			end
			M_XC:
			begin
				render_mode = R_XC;
				go_offs     = 5'd4;
				fetch.bw    = 5'b00001; // 1 of 2
				fetch.sel   = {~pos.cptr, ~pos.cptr, 2'b11};
				fetch.addr  = addr_256c;
			end
			M_TX:
			begin
				render_mode = R_TX;
				go_offs     = 5'd10;
				fetch.bw    = 5'b11100; // 4 of 8
				fetch.sel   = txt_sel;
				fetch.bsl   = txt_bsl;
				fetch.addr  = addr_text;
			end
			M_T0:
			begin
				go_offs  = 5'd10;
				fetch.bw = 5'b11010; // 2 of 8, hi-res ZX
			end
			default: ;
		endcase
	end

	// fetch phase per render mode, counter sits at zero outside the window
	always_comb
	begin
		case (render_mode)
			R_HC:    ftch = &pos.fetch_cnt[1:0];
			R_XC:    ftch = pos.fetch_cnt[0];
			default: ftch = &pos.fetch_cnt;
		endcase
	end

	assign fetch.stb = (pos.pix_start || ftch) && c3;
	assign fetch.col = pos.cnt_col;
	assign fetch.row = pos.cnt_row;

	// raster resolution table
	always_comb
	begin
		case (vconf_d.rres)
			RES_320X200: window = '{9'd108, 9'd428, 9'd76, 9'd276, 6'd41};
			RES_320X240: window = '{9'd108, 9'd428, 9'd56, 9'd296, 6'd41};
			RES_360X288: window = '{9'd88, 9'd448, 9'd32, 9'd320, 6'd46}; // full raster
			default:     window = '{9'd140, 9'd396, 9'd80, 9'd272, 6'd33};
		endcase
	end

endmodule

/* hw/video_top.sv */
// Video mode decoding top
`timescale 1ns/100ps

module video_top
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        wr_stb,
	input  logic [7:0]                  wr_addr,
	input  logic [7:0]                  wr_data,
	input  logic [15:0]                 txt_char,
	output video_fetch_pkg::vid_fetch_t fetch,
	output video_cfg_pkg::vid_window_t  window,
	output video_cfg_pkg::vid_render_e  render_mode,
	output logic                        pix_stb,
	output logic                        vga_hires,
	output logic                        nogfx,
	output logic [9:0]                  x_offs_mode,
	output logic [4:0]                  go_offs
);

	import video_cfg_pkg::*;
	import video_fetch_pkg::*;

	vid_conf_t  vconf;
	logic [7:0] vpage;
	logic [8:0] x_offs;
	logic       page_wr;
	vid_pos_t   pos;
	logic       f1;
	logic       c3;

	// CPU registers
	video_regs u_regs
	(
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_stb  (wr_stb),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.vconf   (vconf),
		.vpage   (vpage),
		.x_offs  (x_offs),
		.page_wr (page_wr)
	);

	// window closes the loop back from the decoder
	video_raster u_raster
	(
		.clk    (clk),
		.arst_n (arst_n),
		.window (window),
		.pos    (pos),
		.f1     (f1),
		.c3     (c3)
	);

	video_mode u_mode
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.vconf       (vconf),
		.vpage       (vpage),
		.x_offs      (x_offs),
		.page_wr     (page_wr),
		.pos         (pos),
		.f1          (f1),
		.c3          (c3),
		.txt_char    (txt_char),
		.window      (window),
		.render_mode (render_mode),
		.x_offs_mode (x_offs_mode),
		.go_offs     (go_offs),
		.pix_stb     (pix_stb),
		.tv_hires    (),  // only used inside the decoder
		.vga_hires   (vga_hires),
		.nogfx       (nogfx),
		.fetch       (fetch),
		.vpage_d     ()
	);

endmodule

/* sim/video_assertions.sv */
// Decoder and raster checks
`timescale 1ns/100ps

module video_assertions
(
	input logic                        clk,
	input logic                        arst_n,
	input logic                        c3,
	input video_cfg_pkg::vid_conf_t    vconf_d,
	input video_fetch_pkg::vid_pos_t   pos,
	input video_fetch_pkg::vid_fetch_t fetch
);

	import video_cfg_pkg::*;
	import video_fetch_pkg::*;

	int fail_cnt = 0; // read by the testbench at the end

	// bandwidth class per mode, group code then cycles
	function automatic logic [4:0] bw_for(input vid_mode_e m);
		case (m)
			M_HC:    return {2'b01, 3'd1};
			M_XC:    return {2'b00, 3'd1};
			M_TX:    return {2'b11, 3'd4};
			M_T0:    return {2'b11, 3'd2};
			default: return {2'b11, 3'd1};
		endcase
	endfunction

	// strobe on c3, only at window begin or on a running column
	stb_on_c3: assert property (@(posedge clk) disable iff (!arst_n)
		fetch.stb |-> c3 && (pos.pix_start || pos.cnt_col != 8'd0))
		else
		begin
			fail_cnt++;
			$error("fetch strobe outside the c3 phase or the window");
		end

	// latched config moves only at line start while no column runs
	conf_at_line: assert property (@(posedge clk) disable iff (!arst_n)
		$changed(vconf_d) |-> $past(pos.line_start && c3) && (pos.cnt_col == 8'd0))
		else
		begin
			fail_cnt++;
			$error("config taken away from line start");
		end

	bw_match: assert property (@(posedge clk) disable iff (!arst_n)
		fetch.bw == bw_for(vconf_d.mode))
		else
		begin
			fail_cnt++;
			$error("bandwidth class does not match the mode");
		end

endmodule

bind video_mode video_assertions mode_chk
(
	.clk     (clk),
	.arst_n  (arst_n),
	.c3      (c3),
	.vconf_d (vconf_d),
	.pos     (pos),
	.fetch   (fetch)
);

/* sim/video_tb.sv */
// Video decoder testbench
`timescale 1ns/100ps
`include "video_macros.svh"

module video_tb;

	import video_cfg_pkg::*;
	import video_fetch_pkg::*;

	localparam int line_clks  = `VID_H_TOTAL * 4; // one pixel period is 4 clk
	localparam int frame_clks = line_clks * `VID_V_TOTAL;
	localparam int n_tests    = 6;

	logic        clk;
	logic        arst_n;
	logic        wr_stb;
	logic [7:0]  wr_addr;
	logic [7:0]  wr_data;
	logic [15:0] txt_char;
	vid_fetch_t  fetch;
	vid_window_t window;
	vid_render_e render_mode;
	logic        pix_stb;
	logic        vga_hires;
	logic        nogfx;
	logic [9:0]  x_offs_mode;
	logic [4:0]  go_offs;
	integer      seed;

	video_top video_top_i
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.wr_stb      (wr_stb),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.txt_char    (txt_char),
		.fetch       (fetch),
		.window      (window),
		.render_mode (render_mode),
		.pix_stb     (pix_stb),
		.vga_hires   (vga_hires),
		.nogfx       (nogfx),
		.x_offs_mode (x_offs_mode),
		.go_offs     (go_offs)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	// three frames per test, the longest wait is one frame
	initial
	begin
		#(n_tests * 3 * frame_clks * 10);
		fail_run("watchdog expired, a test never finished");
	end

	task automatic check_window(input string name, input vid_window_t got, input vid_window_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_render(input string name, input vid_render_e got, input vid_render_e exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_fetch(input string name, input vid_fetch_t got, input vid_fetch_t exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_vec(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	// window centred in the 360x288 active area, plus one partial tile
	function automatic vid_window_t exp_window(input vid_rres_e rres);
		int          w;
		int          h;
		vid_window_t win;
		case (rres)
			RES_320X200:
			begin
				w = 320;
				h = 200;
			end
			RES_320X240:
			begin
				w = 320;
				h = 240;
			end
			RES_360X288:
			begin
				w = 360;
				h = 288;
			end
			default:
			begin
				w = 256;
				h = 192;
			end
		endcase
		win.hpix_beg = 9'(`VID_H_TOTAL - 360 + (360 - w) / 2);
		win.hpix_end = 9'(win.hpix_beg + w);
		win.vpix_beg = 9'(`VID_V_TOTAL - 288 + (288 - h) / 2);
		win.vpix_end = 9'(win.vpix_beg + h);
		win.x_tiles  = 6'(w / 8 + 1);
		return win;
	endfunction

	function automatic vid_render_e exp_render(input vid_mode_e mode);
		case (mode)
			M_HC:    return R_HC;
			M_XC:    return R_XC;
			M_TX:    return R_TX;
			default: return R_ZX; // reserved modes behave as ZX
		endcase
	endfunction

	// group 11 of 8, 01 of 4, 00 of 2, then cycles taken
	function automatic logic [4:0] exp_bw(input vid_mode_e mode);
		case (mode)
			M_HC:    return {2'b01, 3'd1};
			M_XC:    return {2'b00, 3'd1};
			M_TX:    return {2'b11, 3'd4};
			M_T0:    return {2'b11, 3'd2}; // hi-res ZX
			default: return {2'b11, 3'd1};
		endcase
	endfunction

	// fetch lead ahead of the window, in pixel periods
	function automatic logic [4:0] exp_go_offs(input vid_mode_e mode);
		case (mode)
			M_HC:    return 5'd6;
			M_XC:    return 5'd4;
			M_TX:    return 5'd10;
			M_T0:    return 5'd10;
			default: return 5'd18; // ZX and reserved
		endcase
	endfunction

	// expected request for a c3 cycle with a nonzero column
	function automatic vid_fetch_t exp_fetch(input vid_mode_e mode, input logic [7:0] col,
		input logic [8:0] row, input logic [7:0] page, input logic [15:0] txt);
		vid_fetch_t f;
		int         c;
		int         r;
		int         pg;
		int         a;
		c = col;
		r = row;
		pg = page;
		f = '0;
		f.col = col;
		f.row = row;
		f.bw  = exp_bw(mode);
		f.bsl = 2'b10;
		case (mode)
			M_HC:
			begin
				f.stb = (c % 4 == 3);
				f.sel = (c % 2) ? 4'b0011 : 4'b1111;
				a = (pg / 8) * 65536 + r * 128 + c % 128; // 64K words per page group
			end
			M_XC:
			begin
				f.stb = (c % 2 == 1);
				f.sel = (c % 2) ? 4'b0011 : 4'b1111;
				a = (pg / 16) * 131072 + r * 256 + c;
			end
			M_TX:
			begin
				f.stb = (c % 16 == 15);
				a = (pg / 2) * 16384;
				case (c % 4)
					0:
					begin
						f.sel = 4'b0010; // font, second char
						f.bsl = row[0] ? 2'b11 : 2'b00;
						a = a + (1 - pg % 2) * 8192 + txt[15:8] * 4 + (r / 2) % 4;
					end
					1:
					begin
						f.sel = 4'b0011; // char codes
						a = a + (pg % 2) * 8192 + ((r / 8) % 64) * 128 + (c / 4) % 64;
					end
					2:
					begin
						f.sel = 4'b1100; // attributes, next half-row
						a = a + (pg % 2) * 8192 + ((r / 8) % 64) * 128 + 64 + (c / 4) % 64;
					end
					default:
					begin
						f.sel = 4'b0001; // font, first char
						f.bsl = row[0] ? 2'b11 : 2'b00;
						a = a + (1 - pg % 2) * 8192 + txt[7:0] * 4 + (r / 2) % 4;
					end
				endcase
			end
			default:
			begin
				f.stb = (c % 16 == 15);
				f.sel = (c % 2) ? 4'b0011 : 4'b1100;
				if (c % 2)
					a = 3072 + ((r / 8) % 32) * 16 + (c / 2) % 16; // attrs at 0x1800 bytes
				else
					a = ((r / 64) % 4) * 1024 + (r % 8) * 128 + ((r / 8) % 8) * 16 + (c / 2) % 16;
				a = a + pg * 8192;
			end
		endcase
		f.addr = a[20:0];
		return f;
	endfunction

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		wr_stb  = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_stb  = 1'b0;
	endtask

	// returns one cycle after the latch edge
	task automatic wait_line_start;
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > line_clks + 8)
				fail_run("line start did not come within one line");
		end
		while (!video_top_i.pos.line_start);
		@(negedge clk);
	endtask

	task automatic next_sample;
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > frame_clks + line_clks)
				fail_run("no visible column within one frame");
		end
		while (!(video_top_i.c3 && fetch.col != 8'd0));
	endtask

	task automatic check_samples(input int n, input vid_mode_e mode, input logic [7:0] pg,
		input logic [15:0] txt);
		for (int k = 0; k < n; k++)
		begin
			next_sample();
			check_fetch("fetch", fetch, exp_fetch(mode, fetch.col, fetch.row, pg, txt));
		end
	endtask

	task automatic reset_state;
		int          n;
		vid_window_t w;
		w = exp_window(RES_256X192);
		check_render("render_mode", render_mode, R_ZX);
		check_window("window", window, w);
		check_bit("nogfx", nogfx, 1'b0);
		check_vec("x_offs_mode", x_offs_mode, 0);
		n = 0;
		while (fetch.stb !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > frame_clks)
				fail_run("no fetch strobe within one frame after reset");
		end
		if (n < w.vpix_beg * line_clks)
			fail_run("fetch strobe came before the visible window");
		check_vec("fetch.col", fetch.col, 0); // window begin
		check_vec("fetch.row", fetch.row, 0);
	endtask

	// each resolution with a mode, old values kept until line start
	task automatic conf_latch;
		vid_rres_e old_res;
		vid_mode_e old_mode;
		vid_mode_e m;
		old_res  = RES_256X192;
		old_mode = M_ZX;
		for (int i = 0; i < 4; i++)
		begin
			m = vid_mode_e'(i);
			wait_line_start();
			write_reg(`VID_REG_VCONF, 8'((i << 6) | ((i % 2) << 5) | i));
			check_window("window", window, exp_window(old_res));
			check_render("render_mode", render_mode, exp_render(old_mode));
			wait_line_start();
			check_window("window", window, exp_window(vid_rres_e'(i)));
			check_render("render_mode", render_mode, exp_render(m));
			check_vec("fetch.bw", fetch.bw, exp_bw(m));
			check_vec("go_offs", go_offs, exp_go_offs(m));
			check_bit("nogfx", nogfx, i % 2);
			old_res  = vid_rres_e'(i);
			old_mode = m;
		end
	endtask

	task automatic zx_addressing;
		logic [7:0] pg;
		pg = $random(seed);
		write_reg(`VID_REG_VPAGE, pg);
		write_reg(`VID_REG_VCONF, 8'h00);
		wait_line_start();
		check_samples(48, M_ZX, pg, 16'h0); // pixel and attribute columns
	endtask

	task automatic linear_addressing;
		logic [7:0] pg;
		logic [8:0] xo;
		vid_mode_e  m;
		int         exp_x;
		xo = $random(seed);
		pg = $random(seed);
		write_reg(`VID_REG_XOFFS_L, xo[7:0]);
		write_reg(`VID_REG_XOFFS_H, {7'd0, xo[8]});
		write_reg(`VID_REG_VPAGE, pg);
		for (int k = 0; k < 2; k++)
		begin
			m = (k == 0) ? M_HC : M_XC;
			write_reg(`VID_REG_VCONF, {5'd0, m});
			wait_line_start();
			exp_x = (m == M_XC) ? (xo / 2) * 4 + xo % 2 : xo; // fine step kept in bit 0
			check_vec("x_offs_mode", x_offs_mode, exp_x);
			check_samples(32, m, pg, 16'h0);
		end
	endtask

	task automatic text_addressing;
		logic [7:0] pg;
		pg = $random(seed);
		txt_char = $random(seed); // stands in for returned char codes
		write_reg(`VID_REG_VPAGE, pg);
		write_reg(`VID_REG_VCONF, {5'd0, M_TX});
		wait_line_start();
		check_samples(40, M_TX, pg, txt_char);
	endtask

	task automatic hires_and_page;
		logic [7:0] pg;
		logic [8:0] row0;
		write_reg(`VID_REG_VCONF, 8'h00);
		wait_line_start();
		wait_line_start();
		check_bit("vga_hires", vga_hires, 1'b0);
		repeat (8)
		begin
			@(negedge clk);
			check_bit("pix_stb", pix_stb, video_top_i.c3);
		end
		write_reg(`VID_REG_VCONF, {5'd0, M_T0});
		wait_line_start();
		check_bit("vga_hires", vga_hires, 1'b0); // still a line behind
		check_vec("go_offs", go_offs, exp_go_offs(M_T0));
		repeat (8)
		begin
			@(negedge clk);
			check_bit("pix_stb", pix_stb, video_top_i.f1);
		end
		wait_line_start();
		check_bit("vga_hires", vga_hires, 1'b1);
		// page port write lands inside the same line
		wait_line_start();
		next_sample();
		row0 = fetch.row;
		pg = $random(seed);
		write_reg(`VID_REG_7FFD, pg);
		@(negedge clk);
		check_samples(4, M_T0, pg, 16'h0);
		check_vec("fetch.row", fetch.row, row0);
	endtask

	initial
	begin
		seed     = 32'hed95;
		arst_n   = 1'b0;
		wr_stb   = 1'b0;
		wr_addr  = 8'h00;
		wr_data  = 8'h00;
		txt_char = 16'h0000;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		reset_state();
		conf_latch();
		zx_addressing();
		linear_addressing();
		text_addressing();
		hires_and_page();
		if (video_top_i.u_mode.mode_chk.fail_cnt != 0)
			fail_run("concurrent assertions failed during the run");
		else
		begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* build.f */
+incdir+hw
hw/video_cfg_pkg.sv
hw/video_fetch_pkg.sv
hw/video_regs.sv
hw/video_raster.sv
hw/video_mode.sv
hw/video_top.sv
sim/video_assertions.sv
sim/video_tb.sv

/* Bender.yml */
package:
  name: video_mode

sources:
  - include_dirs:
      - hw
    files:
      - hw/video_cfg_pkg.sv
      - hw/video_fetch_pkg.sv
      - hw/video_regs.sv
      - hw/video_raster.sv
      - hw/video_mode.sv
      - hw/video_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/video_assertions.sv
      - sim/video_tb.sv
